//--- design/lsu_ctrl.sv
// controller of the load/store unit that accepts core strobes and sequences the memory beats
`timescale 1ns/10ps

module lsu_ctrl
(
  input  logic               clk,
  input  logic               rst_n,

  // core side
  input  logic               req_valid_i,     // one cycle strobe
  input  lsu_pkg::lsu_req_t  req_i,           // sampled with the strobe
  output logic               busy_o,          // strobes are dropped while high
  output logic               resp_valid_o,    // one cycle strobe on the final rvalid

  // request generator
  output lsu_pkg::lsu_req_t  held_req_o,      // accepted request
  input  lsu_pkg::mem_req_t  first_i,         // first part beat
  input  lsu_pkg::mem_req_t  second_i,        // second part beat
  input  logic               misaligned_i,    // access needs both beats

  // context buffer
  output lsu_pkg::lsu_ctx_t  ctx_o,           // context of the held request
  output logic               first_gnt_o,     // capture context
  output logic               first_rvalid_o,  // capture first part data

  // memory side
  output logic               mem_req_o,
  output lsu_pkg::mem_req_t  mem_o,
  input  logic               mem_gnt_i,
  input  logic               mem_rvalid_i
);

  typedef enum logic [2:0] {
    S_IDLE,  // nothing in flight
    S_GNT1,  // first beat waits for grant
    S_RV1,   // first beat waits for rvalid
    S_GNT2,  // second beat waits for grant
    S_RV2    // second beat waits for rvalid
  } state_e;

  state_e            state_q;
  state_e            state_d;
  lsu_pkg::lsu_req_t held_q;    // request under execution
  logic              accept;    // strobe taken this cycle
  logic              part_sel;  // second part on the bus

  assign accept = req_valid_i && (state_q == S_IDLE);

  ////////////////////////////// request hold
  // request stays put until the access completes
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      held_q <= '0;
    else if (accept)
      held_q <= req_i;
  end

  assign held_req_o = held_q;

  // context for the read path that the buffer captures at the first grant
  always_comb
  begin
    ctx_o.mem_type   = held_q.mem_type;
    ctx_o.offset     = held_q.addr[1:0];
    ctx_o.sign_ext   = held_q.sign_ext;
    ctx_o.we         = held_q.we;
    ctx_o.misaligned = misaligned_i;
  end

  ////////////////////////////// FSM
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= S_IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d        = state_q;
    first_gnt_o    = 1'b0;
    first_rvalid_o = 1'b0;
    resp_valid_o   = 1'b0;
    case (state_q)
      S_IDLE:
      begin
        if (accept)
          state_d = S_GNT1;  // request goes out next cycle
      end
      S_GNT1:
      begin
        if (mem_gnt_i)
        begin
          first_gnt_o = 1'b1;
          state_d     = S_RV1;
        end
      end
      S_RV1:
      begin
        if (mem_rvalid_i && misaligned_i)
        begin
          first_rvalid_o = 1'b1;  // keep the first word
          state_d        = S_GNT2;
        end
        else if (mem_rvalid_i)
        begin
          resp_valid_o = 1'b1;    // single beat done
          state_d      = S_IDLE;
        end
      end
      S_GNT2:
      begin
        if (mem_gnt_i)
          state_d = S_RV2;
      end
      S_RV2:
      begin
        if (mem_rvalid_i)
        begin
          resp_valid_o = 1'b1;
          state_d      = S_IDLE;
        end
      end
      default:
      begin
        state_d = S_IDLE;
      end
    endcase
  end

  ////////////////////////////// outputs
  assign busy_o    = (state_q != S_IDLE);
  assign part_sel  = (state_q == S_GNT2) || (state_q == S_RV2);
  assign mem_req_o = (state_q == S_GNT1) || (state_q == S_GNT2);  // held until grant
  assign mem_o     = part_sel ? second_i : first_i;

endmodule

//--- design/lsu_ctx_buf.sv
// context buffer of the load/store unit, keeps access info and first part read data until completion
`timescale 1ns/10ps

module lsu_ctx_buf
(
  input  logic                       clk,
  input  logic                       rst_n,

  // strobes from the controller
  input  logic                       first_gnt_i,     // first beat granted
  input  logic                       first_rvalid_i,  // first beat of a split access returned

  // captured data
  input  lsu_pkg::lsu_ctx_t          ctx_i,           // context of the held request
  input  logic [lsu_pkg::DATA_W-1:0] rdata_i,         // raw memory read data
  input  logic                       mem_err_i,       // bus error with the rvalid

  // to the read data aligner
  output lsu_pkg::lsu_ctx_t          ctx_o,           // context of the access in flight
  output logic [lsu_pkg::DATA_W-1:0] first_rdata_o,   // word read by the first part
  output logic                       err_seen_o       // first part reported an error
);

  lsu_pkg::lsu_ctx_t          ctx_q;
  logic [lsu_pkg::DATA_W-1:0] first_rdata_q;
  logic                       err_q;

  ////////////////////////////// context
  // taken once per access, the held request may change afterwards
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctx_q <= '0;
    end
    else if (first_gnt_i)
    begin
      ctx_q <= ctx_i;
    end
  end

  ////////////////////////////// first part data
  // the upper bytes of the first word are needed when the second word returns
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      first_rdata_q <= '0;
    end
    else if (first_rvalid_i)
    begin
      first_rdata_q <= rdata_i;  // kept raw, aligned later
    end
  end

  ////////////////////////////// sticky error
  // an error on the first part must still show on the final response
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      err_q <= 1'b0;
    end
    else if (first_gnt_i)
    begin
      err_q <= 1'b0;       // new access starts clean
    end
    else if (first_rvalid_i)
    begin
      err_q <= mem_err_i;  // only the first part of a split access
    end
  end

  assign ctx_o         = ctx_q;
  assign first_rdata_o = first_rdata_q;
  assign err_seen_o    = err_q;

endmodule

//--- design/lsu_pkg.sv
// shared widths, access types and packed bus structs of the load/store unit, used by scoped name
package lsu_pkg;

  ////////////////////////////// widths
  localparam int ADDR_W = 32;  // byte address, one word
  localparam int DATA_W = 32;  // data bus, one word
  localparam int BE_W   = 4;   // one enable per byte lane

  ////////////////////////////// access size
  // encoding follows the core decoder, 2'b11 is not issued
  typedef enum logic [1:0] {
    MEM_WORD = 2'b00,  // 32 bit access
    MEM_HALF = 2'b01,  // 16 bit access
    MEM_BYTE = 2'b10   // 8 bit access
  } mem_type_e;

  ////////////////////////////// core side
  // one load or store as issued by the core
  typedef struct packed {
    logic              we;        // 1 for store
    mem_type_e         mem_type;  // word, half or byte
    logic              sign_ext;  // sign extend loads
    logic [ADDR_W-1:0] addr;      // byte address, may be unaligned
    logic [DATA_W-1:0] wdata;     // store data, lsb aligned
  } lsu_req_t;

  // result handed back to the core with resp_valid_o
  typedef struct packed {
    logic [DATA_W-1:0] rdata;      // extended load data
    logic              load_err;   // bus error on a load
    logic              store_err;  // bus error on a store
  } lsu_resp_t;

  ////////////////////////////// memory side
  // one beat on the req/gnt/rvalid data port
  typedef struct packed {
    logic [ADDR_W-1:0] addr;   // word aligned address
    logic              we;     // write beat
    logic [BE_W-1:0]   be;     // byte lane enables
    logic [DATA_W-1:0] wdata;  // lane rotated store data
  } mem_req_t;

  ////////////////////////////// access context
  // what the read path needs to know once the request is gone
  typedef struct packed {
    mem_type_e mem_type;    // access size
    logic [1:0] offset;     // byte offset inside the first word
    logic      sign_ext;    // extension mode for loads
    logic      we;          // routes the error bit
    logic      misaligned;  // access is split into two beats
  } lsu_ctx_t;

endpackage

//--- design/lsu_rdata_align.sv
// read data aligner of the load/store unit, merges split words, extends loads and forms the response
`timescale 1ns/10ps

module lsu_rdata_align
(
  input  lsu_pkg::lsu_ctx_t          ctx_i,          // context of the access in flight
  input  logic [lsu_pkg::DATA_W-1:0] first_rdata_i,  // first part word, split accesses only
  input  logic [lsu_pkg::DATA_W-1:0] mem_rdata_i,    // word returned with this rvalid
  input  logic                       mem_err_i,      // bus error with this rvalid
  input  logic                       err_seen_i,     // error kept from the first part
  output lsu_pkg::lsu_resp_t         resp_o          // valid with resp_valid_o
);

  logic [2*lsu_pkg::DATA_W-1:0] rdata_pair;     // two words, low word first
  logic [2*lsu_pkg::DATA_W-1:0] rdata_shift;    // pair moved down by the offset
  logic [lsu_pkg::DATA_W-1:0]   rdata_ext;      // extended result
  logic                         err;            // error over both parts

  ////////////////////////////// word assembly
  // a split access reads the first word, then the next one,
  // so the current word goes on top of the buffered one.
  // an aligned access has everything in the current word.
  always_comb
  begin
    if (ctx_i.misaligned)
    begin
      rdata_pair = {mem_rdata_i, first_rdata_i};
    end
    else
    begin
      rdata_pair = {{lsu_pkg::DATA_W{1'b0}}, mem_rdata_i};
    end
  end

  // bring the addressed byte down to lane 0
  assign rdata_shift = rdata_pair >> {ctx_i.offset, 3'b000};

  ////////////////////////////// extension
  always_comb
  begin
    case (ctx_i.mem_type)
      lsu_pkg::MEM_WORD:
      begin
        rdata_ext = rdata_shift[31:0];  // nothing to extend
      end
      lsu_pkg::MEM_HALF:
      begin
        if (ctx_i.sign_ext)
          rdata_ext = {{16{rdata_shift[15]}}, rdata_shift[15:0]};
        else
          rdata_ext = {16'h0000, rdata_shift[15:0]};
      end
      default:
      begin
        // byte, also taken for the unused code
        if (ctx_i.sign_ext)
          rdata_ext = {{24{rdata_shift[7]}}, rdata_shift[7:0]};
        else
          rdata_ext = {24'h00_0000, rdata_shift[7:0]};
      end
    endcase
  end

  ////////////////////////////// response
  // either part failing fails the whole access
  assign err = mem_err_i | err_seen_i;

  always_comb
  begin
    resp_o.rdata     = rdata_ext;
    resp_o.load_err  = err & ~ctx_i.we;
    resp_o.store_err = err &  ctx_i.we;
  end

endmodule

//--- design/lsu_req_gen.sv
// memory beat generator of the load/store unit, turns the held core request into one or two beats
`timescale 1ns/10ps

module lsu_req_gen
(
  input  lsu_pkg::lsu_req_t req_i,        // request held by the controller
  output lsu_pkg::mem_req_t first_o,      // beat for the first word
  output lsu_pkg::mem_req_t second_o,     // beat for the following word
  output logic              misaligned_o  // second beat is needed
);

  logic [1:0]                 offset;     // byte offset in the word
  logic [2*lsu_pkg::BE_W-1:0] be_span;    // lane mask over two words
  logic [lsu_pkg::DATA_W-1:0] wdata_rot;  // store data moved to its lanes
  logic [lsu_pkg::ADDR_W-1:0] word_addr;  // address with offset cleared

  assign offset    = req_i.addr[1:0];
  assign word_addr = {req_i.addr[lsu_pkg::ADDR_W-1:2], 2'b00};

  ////////////////////////////// byte enables
  // the access mask is laid over two consecutive words and shifted by the offset,
  // the low nibble then belongs to the first word and the high nibble to the second
  always_comb
  begin
    case (req_i.mem_type)
      lsu_pkg::MEM_WORD:
      begin
        be_span = 8'b0000_1111 << offset;  // lanes k..3, then 0..k-1
      end
      lsu_pkg::MEM_HALF:
      begin
        be_span = 8'b0000_0011 << offset;  // only offset 3 spills over
      end
      default:
      begin
        be_span = 8'b0000_0001 << offset;  // a byte never spills
      end
    endcase
  end

  // anything left in the upper nibble needs a second access
  assign misaligned_o = |be_span[2*lsu_pkg::BE_W-1:lsu_pkg::BE_W];

  ////////////////////////////// write data
  // rotate left by the offset in bytes so that byte 0 of the
  // store data sits on the first enabled lane, the bytes that wrap
  // around land on the low lanes used by the second part
  always_comb
  begin
    case (offset)
      2'b00:   wdata_rot = req_i.wdata;
      2'b01:   wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10:   wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata_rot = {req_i.wdata[ 7:0], req_i.wdata[31: 8]};
    endcase
  end

  ////////////////////////////// beats
  // first part, the word that holds the start address
  always_comb
  begin
    first_o.addr  = word_addr;
    first_o.we    = req_i.we;
    first_o.be    = be_span[lsu_pkg::BE_W-1:0];
    first_o.wdata = wdata_rot;
  end

  // second part, always the next word up
  always_comb
  begin
    second_o.addr  = word_addr + 32'd4;  // wraps at the top of memory
    second_o.we    = req_i.we;
    second_o.be    = be_span[2*lsu_pkg::BE_W-1:lsu_pkg::BE_W];
    second_o.wdata = wdata_rot;          // same rotation, other lanes enabled
  end

endmodule

//--- design/lsu_top.sv
// top level of the load/store unit, connects controller, beat generator, context buffer and aligner
`timescale 1ns/10ps

module lsu_top
(
  input  logic                       clk,
  input  logic                       rst_n,

  // core side
  input  logic                       req_valid_i,
  input  lsu_pkg::lsu_req_t          req_i,
  output logic                       resp_valid_o,
  output lsu_pkg::lsu_resp_t         resp_o,
  output logic                       busy_o,

  // data memory side
  output logic                       mem_req_o,
  output lsu_pkg::mem_req_t          mem_o,
  input  logic                       mem_gnt_i,
  input  logic                       mem_rvalid_i,
  input  logic                       mem_err_i,
  input  logic [lsu_pkg::DATA_W-1:0] mem_rdata_i
);

  lsu_pkg::lsu_req_t          held_req;      // request under execution
  lsu_pkg::mem_req_t          first_beat;    // first word access
  lsu_pkg::mem_req_t          second_beat;   // next word access
  logic                       misaligned;    // split access
  lsu_pkg::lsu_ctx_t          ctx_cur;       // context of the held request
  lsu_pkg::lsu_ctx_t          ctx_held;      // context captured at grant
  logic                       first_gnt;
  logic                       first_rvalid;
  logic [lsu_pkg::DATA_W-1:0] first_rdata;
  logic                       err_seen;

  lsu_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .busy_o         (busy_o),
    .resp_valid_o   (resp_valid_o),
    .held_req_o     (held_req),
    .first_i        (first_beat),
    .second_i       (second_beat),
    .misaligned_i   (misaligned),
    .ctx_o          (ctx_cur),
    .first_gnt_o    (first_gnt),
    .first_rvalid_o (first_rvalid),
    .mem_req_o      (mem_req_o),
    .mem_o          (mem_o),
    .mem_gnt_i      (mem_gnt_i),
    .mem_rvalid_i   (mem_rvalid_i)
  );

  lsu_req_gen u_req_gen (
    .req_i        (held_req),
    .first_o      (first_beat),
    .second_o     (second_beat),
    .misaligned_o (misaligned)
  );

  lsu_ctx_buf u_ctx_buf (
    .clk            (clk),
    .rst_n          (rst_n),
    .first_gnt_i    (first_gnt),
    .first_rvalid_i (first_rvalid),
    .ctx_i          (ctx_cur),
    .rdata_i        (mem_rdata_i),
    .mem_err_i      (mem_err_i),
    .ctx_o          (ctx_held),
    .first_rdata_o  (first_rdata),
    .err_seen_o     (err_seen)
  );

  lsu_rdata_align u_rdata_align (
    .ctx_i         (ctx_held),
    .first_rdata_i (first_rdata),
    .mem_rdata_i   (mem_rdata_i),
    .mem_err_i     (mem_err_i),
    .err_seen_i    (err_seen),
    .resp_o        (resp_o)
  );

endmodule

//--- dv/lsu_asserts.sv
// protocol checks of the load/store unit memory port and response strobe, bound into lsu_top
`timescale 1ns/10ps

module lsu_asserts
(
  input logic              clk,
  input logic              rst_n,
  input logic              mem_req_o,
  input lsu_pkg::mem_req_t mem_o,
  input logic              mem_gnt_i,
  input logic              mem_rvalid_i,
  input logic              resp_valid_o
);

  logic outstanding;  // granted beat waiting for its rvalid

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      outstanding <= 1'b0;
    else if (mem_req_o && mem_gnt_i)
      outstanding <= 1'b1;
    else if (mem_rvalid_i)
      outstanding <= 1'b0;  // one beat in flight at most
  end

  ////////////////////////////// memory port
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_o))
    else $error("memory beat changed before its grant");

  a_rvalid_owed: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rvalid_i |-> outstanding)
    else $error("rvalid without an outstanding beat");

  a_no_req_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding |-> !mem_req_o)
    else $error("new beat requested while rvalid is awaited");

  ////////////////////////////// core port
  a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_o |=> !resp_valid_o)
    else $error("response strobe longer than one cycle");

endmodule

bind lsu_top lsu_asserts u_lsu_asserts (.*);

//--- dv/lsu_tb.sv
// testbench of the load/store unit that runs a table of loads and stores against a memory model
`timescale 1ns/10ps

module lsu_tb;

  typedef struct {
    string              name;
    bit                 we;
    lsu_pkg::mem_type_e mt;
    bit                 sx;
    logic [31:0]        addr;
    logic [31:0]        wdata;
    logic [31:0]        exp;    // only used when known is set
    bit                 known;
    int                 beats;
    bit                 err;
    bit                 poke;   // fire a second strobe while busy
  } test_t;

  logic               clk;
  logic               rst_n;
  logic               req_valid_i;
  lsu_pkg::lsu_req_t  req_i;
  logic               resp_valid_o;
  lsu_pkg::lsu_resp_t resp_o;
  logic               busy_o;
  logic               mem_req_o;
  lsu_pkg::mem_req_t  mem_o;
  logic               mem_gnt_i;
  logic               mem_rvalid_i;
  logic               mem_err_i;
  logic [31:0]        mem_rdata_i;

  logic [31:0]        mem [0:63];     // model storage written by beats
  logic [7:0]         shadow [0:255]; // expected contents per byte address
  test_t              tests [$];
  lsu_pkg::lsu_resp_t last_resp;
  int                 resp_cnt;
  int                 beat_cnt;
  int                 errors;
  int                 seed;
  bit                 timed_out;

  lsu_top u_lsu_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  function automatic logic [7:0] fill_byte(int a);
    return 8'(a * 37 + 11);  // every address bit counts
  endfunction

  ////////////////////////////// memory model
  initial
  begin : mem_model
    int     d;
    logic   err;
    mem_lsu_beat: forever
    begin
      lsu_pkg::mem_req_t beat;
      @(posedge clk);
      #1;
      if (rst_n && mem_req_o)
      begin
        #1;
        d = $random(seed) & 3;
        repeat (d)
        begin
          @(posedge clk);
          #2;
        end
        mem_gnt_i = 1'b1;
        beat      = mem_o;        // held stable until the grant
        @(posedge clk);
        #2;
        mem_gnt_i = 1'b0;
        beat_cnt++;
        err = (beat.addr >= 32'hF0);
        if (beat.we && !err)
          for (int j = 0; j < 4; j++)
            if (beat.be[j])
              mem[beat.addr[7:2]][8*j +: 8] = beat.wdata[8*j +: 8];
        d = $random(seed) & 3;
        repeat (d)
        begin
          @(posedge clk);
          #2;
        end
        mem_rvalid_i = 1'b1;
        mem_err_i    = err;
        mem_rdata_i  = err ? 32'hDEAD_BEEF : mem[beat.addr[7:2]];
        @(posedge clk);
        #2;
        mem_rvalid_i = 1'b0;
        mem_err_i    = 1'b0;
      end
    end
  end

  // responses sampled mid cycle
  always @(negedge clk)
  begin
    if (resp_valid_o)
    begin
      resp_cnt++;
      last_resp = resp_o;
    end
  end

  ////////////////////////////// expected values
  function automatic int size_of(lsu_pkg::mem_type_e mt);
    return (mt == lsu_pkg::MEM_WORD) ? 4 : (mt == lsu_pkg::MEM_HALF) ? 2 : 1;
  endfunction

  // little endian read of the shadow followed by zero or sign extension
  function automatic logic [31:0] expect_load(logic [31:0] a, lsu_pkg::mem_type_e mt, bit sx);
    logic [31:0] v;
    int          n;
    v = '0;
    n = size_of(mt);
    for (int i = 0; i < n; i++)
      v[8*i +: 8] = shadow[8'(a + i)];
    if (sx && v[8*n-1])
      for (int i = 8 * n; i < 32; i++)
        v[i] = 1'b1;
    return v;
  endfunction

  task automatic shadow_store(logic [31:0] a, lsu_pkg::mem_type_e mt, logic [31:0] wd);
    for (int i = 0; i < size_of(mt); i++)
      if (a + i < 32'hF0)
        shadow[a + i] = wd[8*i +: 8];  // error range is never written
  endtask

  task automatic add_test(string nm, bit we, lsu_pkg::mem_type_e mt, bit sx, logic [31:0] a,
                          logic [31:0] wd, logic [31:0] ex, bit kn, int bt, bit er, bit pk);
    tests.push_back('{nm, we, mt, sx, a, wd, ex, kn, bt, er, pk});
  endtask

  ////////////////////////////// bounded waits
  task automatic wait_resp(int start, output bit ok);
    int n;
    n = 0;
    while (resp_cnt == start && n < 200)
    begin
      @(negedge clk);
      n++;
    end
    ok = (resp_cnt != start);
  endtask

  task automatic wait_idle(output bit ok);
    int n;
    n = 0;
    while (busy_o && n < 200)
    begin
      @(negedge clk);
      n++;
    end
    ok = !busy_o;
  endtask

  ////////////////////////////// stimulus
  initial
  begin
    test_t       t;
    int          start;
    int          fails;
    bit          ok;
    logic [31:0] exp_d;
    seed = 86;
    rst_n = 1'b0;
    req_valid_i = 1'b0;
    req_i = '0;
    mem_gnt_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_err_i = 1'b0;
    mem_rdata_i = '0;
    resp_cnt = 0;
    beat_cnt = 0;
    errors = 0;
    timed_out = 1'b0;
    for (int w = 0; w < 64; w++)
      for (int j = 0; j < 4; j++)
      begin
        mem[w][8*j +: 8]  = fill_byte(4 * w + j);
        shadow[4 * w + j] = fill_byte(4 * w + j);
      end

    // aligned word round trip
    add_test("sw_aligned", 1, lsu_pkg::MEM_WORD, 0, 32'h10, 32'hCAFE_F00D, 0, 0, 1, 0, 0);
    add_test("lw_aligned", 0, lsu_pkg::MEM_WORD, 0, 32'h10, 0, 32'hCAFE_F00D, 1, 1, 0, 0);
    // partial stores keep the other lanes
    add_test("sb_off1", 1, lsu_pkg::MEM_BYTE, 0, 32'h21, 32'h0000_00AB, 0, 0, 1, 0, 0);
    add_test("sh_off2", 1, lsu_pkg::MEM_HALF, 0, 32'h22, 32'h0000_1234, 0, 0, 1, 0, 0);
    add_test("lw_lanes_a", 0, lsu_pkg::MEM_WORD, 0, 32'h20, 0, 0, 0, 1, 0, 0);
    add_test("sb_off0", 1, lsu_pkg::MEM_BYTE, 0, 32'h24, 32'h0000_0011, 0, 0, 1, 0, 0);
    add_test("sb_off3", 1, lsu_pkg::MEM_BYTE, 0, 32'h27, 32'h0000_0099, 0, 0, 1, 0, 0);
    add_test("sh_off1", 1, lsu_pkg::MEM_HALF, 0, 32'h29, 32'h0000_5A6B, 0, 0, 1, 0, 0);
    add_test("lw_lanes_b", 0, lsu_pkg::MEM_WORD, 0, 32'h24, 0, 0, 0, 1, 0, 0);
    add_test("lw_lanes_c", 0, lsu_pkg::MEM_WORD, 0, 32'h28, 0, 0, 0, 1, 0, 0);
    add_test("sh_off0", 1, lsu_pkg::MEM_HALF, 0, 32'h2C, 32'h0000_C3D2, 0, 0, 1, 0, 0);
    add_test("sb_off2", 1, lsu_pkg::MEM_BYTE, 0, 32'h2E, 32'h0000_00E7, 0, 0, 1, 0, 0);
    add_test("lw_lanes_d", 0, lsu_pkg::MEM_WORD, 0, 32'h2C, 0, 0, 0, 1, 0, 0);
    // extension checks on the bytes 01 7f ff 80
    add_test("sw_ext", 1, lsu_pkg::MEM_WORD, 0, 32'h30, 32'h80FF_7F01, 0, 0, 1, 0, 0);
    add_test("lb_off0", 0, lsu_pkg::MEM_BYTE, 1, 32'h30, 0, 32'h0000_0001, 1, 1, 0, 0);
    add_test("lbu_off1", 0, lsu_pkg::MEM_BYTE, 0, 32'h31, 0, 32'h0000_007F, 1, 1, 0, 0);
    add_test("lb_off2", 0, lsu_pkg::MEM_BYTE, 1, 32'h32, 0, 32'hFFFF_FFFF, 1, 1, 0, 0);
    add_test("lb_off3", 0, lsu_pkg::MEM_BYTE, 1, 32'h33, 0, 32'hFFFF_FF80, 1, 1, 0, 0);
    add_test("lbu_off3", 0, lsu_pkg::MEM_BYTE, 0, 32'h33, 0, 32'h0000_0080, 1, 1, 0, 0);
    add_test("lh_off0", 0, lsu_pkg::MEM_HALF, 1, 32'h30, 0, 32'h0000_7F01, 1, 1, 0, 0);
    add_test("lh_off1", 0, lsu_pkg::MEM_HALF, 1, 32'h31, 0, 32'hFFFF_FF7F, 1, 1, 0, 0);
    add_test("lhu_off2", 0, lsu_pkg::MEM_HALF, 0, 32'h32, 0, 32'h0000_80FF, 1, 1, 0, 0);
    add_test("lh_off2", 0, lsu_pkg::MEM_HALF, 1, 32'h32, 0, 32'hFFFF_80FF, 1, 1, 0, 0);
    // split accesses over a word boundary
    add_test("sw_off1", 1, lsu_pkg::MEM_WORD, 0, 32'h41, 32'h1122_3344, 0, 0, 2, 0, 0);
    add_test("lw_off1", 0, lsu_pkg::MEM_WORD, 0, 32'h41, 0, 32'h1122_3344, 1, 2, 0, 0);
    add_test("sw_off2", 1, lsu_pkg::MEM_WORD, 0, 32'h4A, 32'hA5B6_C7D8, 0, 0, 2, 0, 0);
    add_test("lw_off2", 0, lsu_pkg::MEM_WORD, 0, 32'h4A, 0, 32'hA5B6_C7D8, 1, 2, 0, 0);
    add_test("sw_off3", 1, lsu_pkg::MEM_WORD, 0, 32'h57, 32'h0F1E_2D3C, 0, 0, 2, 0, 0);
    add_test("lw_off3", 0, lsu_pkg::MEM_WORD, 0, 32'h57, 0, 32'h0F1E_2D3C, 1, 2, 0, 0);
    add_test("sh_off3", 1, lsu_pkg::MEM_HALF, 0, 32'h63, 32'h0000_BEEF, 0, 0, 2, 0, 0);
    add_test("lh_off3", 0, lsu_pkg::MEM_HALF, 1, 32'h63, 0, 32'hFFFF_BEEF, 1, 2, 0, 0);
    add_test("lw_nbr", 0, lsu_pkg::MEM_WORD, 0, 32'h60, 0, 0, 0, 1, 0, 0);
    // bus errors on single beats and on one part of a split access
    add_test("lw_err", 0, lsu_pkg::MEM_WORD, 0, 32'hF4, 0, 0, 0, 1, 1, 0);
    add_test("sw_err", 1, lsu_pkg::MEM_WORD, 0, 32'hF8, 32'h1234_5678, 0, 0, 1, 1, 0);
    add_test("lw_err_2nd", 0, lsu_pkg::MEM_WORD, 0, 32'hEE, 0, 0, 0, 2, 1, 0);
    add_test("sh_err_2nd", 1, lsu_pkg::MEM_HALF, 0, 32'hEF, 32'h0000_7711, 0, 0, 2, 1, 0);
    add_test("lw_err_1st", 0, lsu_pkg::MEM_WORD, 0, 32'hFFFF_FFFE, 0, 0, 0, 2, 1, 0);
    add_test("lw_below_err", 0, lsu_pkg::MEM_WORD, 0, 32'hEC, 0, 0, 0, 1, 0, 0);
    // strobe while busy is dropped
    add_test("lw_busy_drop", 0, lsu_pkg::MEM_WORD, 0, 32'h10, 0, 32'hCAFE_F00D, 1, 1, 0, 1);

    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    foreach (tests[i])
    begin
      t = tests[i];
      fails = 0;
      wait_idle(ok);
      start    = resp_cnt;
      beat_cnt = 0;
      @(posedge clk);
      #2;
      req_valid_i = 1'b1;
      req_i = '{we: t.we, mem_type: t.mt, sign_ext: t.sx, addr: t.addr, wdata: t.wdata};
      @(posedge clk);
      #2;
      req_valid_i = 1'b0;
      if (busy_o !== 1'b1)
      begin
        $display("** Error %s busy expected %b actual %b", t.name, 1'b1, busy_o);
        fails++;
      end
      if (t.poke)
      begin
        req_valid_i = 1'b1;  // store that must never reach memory
        req_i = '{we: 1'b1, mem_type: lsu_pkg::MEM_WORD, sign_ext: 1'b0,
                  addr: 32'h80, wdata: 32'h0BAD_0BAD};
        @(posedge clk);
        #2;
        req_valid_i = 1'b0;
      end
      wait_resp(start, ok);
      if (ok)
        wait_idle(ok);
      if (!ok)
      begin
        $display("timeout in %s, no response or unit stuck busy", t.name);
        timed_out = 1'b1;
        break;
      end
      repeat (3) @(negedge clk);  // room for a stray response
      exp_d = expect_load(t.addr, t.mt, t.sx);
      if (t.we)
        shadow_store(t.addr, t.mt, t.wdata);
      if (resp_cnt != start + 1)
      begin
        $display("** Error %s responses expected %0d actual %0d", t.name, 1, resp_cnt - start);
        fails++;
      end
      if (beat_cnt != t.beats)
      begin
        $display("** Error %s beats expected %0d actual %0d", t.name, t.beats, beat_cnt);
        fails++;
      end
      if (last_resp.load_err != (t.err && !t.we) || last_resp.store_err != (t.err && t.we))
      begin
        $display("** Error %s err expected %b actual %b/%b", t.name, t.err,
                 last_resp.load_err, last_resp.store_err);
        fails++;
      end
      if (!t.we && !t.err && last_resp.rdata != exp_d)
      begin
        $display("** Error %s rdata expected %h actual %h", t.name, exp_d, last_resp.rdata);
        fails++;
      end
      if (t.known && exp_d != t.exp)  // table value against the shadow
      begin
        $display("** Error %s table data expected %h actual %h", t.name, t.exp, exp_d);
        fails++;
      end
      errors += fails;
      $display("%-14s %s", t.name, (fails == 0) ? "ok" : "FAILED");
    end

    $display("%0d tests, %0d errors", tests.size(), errors);
    if (errors == 0 && !timed_out)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- lsu_top.f
design/lsu_pkg.sv
design/lsu_req_gen.sv
design/lsu_ctx_buf.sv
design/lsu_rdata_align.sv
design/lsu_ctrl.sv
design/lsu_top.sv
dv/lsu_asserts.sv
dv/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the load/store unit testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f lsu_top.f --top-module lsu_tb -o lsu_sim \
  && ./obj_dir/lsu_sim | tee /dev/stderr | grep -q "Test passed" \
  && exit 0 \
  || exit 1
